// File: lsu_core.f
source/lsu_pkg.sv
source/lsu_agen.sv
source/lsu_dmem.sv
source/lsu_track.sv
source/lsu_writeback.sv
source/lsu_top.sv
testbench/lsu_chk.sv
testbench/lsu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the load-store unit testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module lsu_tb \
    -f lsu_core.f \
    --Mdir "$BUILD_DIR" \
    -o lsu_sim

# Simulation status alone is not trusted, the log decides
status=0
"./$BUILD_DIR/lsu_sim" > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -qx "Everything OK" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed, exit status $status"
exit 1

// File: testbench/lsu_tb.sv
// Load-store unit testbench: clock, reset, stimulus tasks, reference model and writeback compare
module lsu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    localparam int unsigned ADDR_LEN    = 6;
    localparam int unsigned MEM_BYTES   = 4 << ADDR_LEN;
    localparam int unsigned MEM_WORDS   = 1 << ADDR_LEN;
    localparam int          DRAIN_LIMIT = 20;

    logic        clk;
    logic        rst;
    logic        req_valid;
    lsu_req_t    req;
    logic        wb_valid;
    lsu_wb_t     wb;

    // Byte image of the data memory, index wraps like the DUT address
    logic [7:0]  shadow [MEM_BYTES];
    // Expected records in issue order
    lsu_wb_t     exp_q [$];
    logic [31:0] lcg_state;
    logic [4:0]  rob_cnt;
    int          value_errors;
    int          protocol_errors;
    int          checked;

    lsu_top #(
        .DMEM_ADDR_LEN (ADDR_LEN)
    ) dut0 (
        .clk_i       (clk),
        .rst_i       (rst),
        .req_valid_i (req_valid),
        .req_i       (req),
        .wb_valid_o  (wb_valid),
        .wb_o        (wb)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    // LCG step, numerical recipes constants
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // I-type load, rd and rs1 fields are don't care here
    function automatic logic [31:0] load_inst(logic [2:0] f3, logic [11:0] imm);
        return {imm, 5'd1, f3, 5'd2, OP_LOAD};
    endfunction

    // S-type store, immediate split around the register fields
    function automatic logic [31:0] store_inst(logic [2:0] f3, logic [11:0] imm);
        return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], OP_STORE};
    endfunction

    // Expected record for one request; stores also update the shadow bytes
    function automatic lsu_wb_t model_access(lsu_req_t r);
        lsu_wb_t               res;
        logic [6:0]            opcode;
        logic [2:0]            f3;
        logic [31:0]           imm;
        logic [31:0]           addr;
        logic [31:0]           data;
        logic [ADDR_LEN+1:0]   pos;
        int unsigned           nbytes;
        logic                  is_ld;
        logic                  is_st;
        logic                  bad;

        opcode = r.inst[6:0];
        f3     = r.inst[14:12];
        is_ld  = (opcode == OP_LOAD);
        is_st  = (opcode == OP_STORE);
        if (is_st) begin
            imm = {{20{r.inst[31]}}, r.inst[31:25], r.inst[11:7]};
        end else begin
            imm = {{20{r.inst[31]}}, r.inst[31:20]};
        end
        addr = r.rs1_value + imm;
        case (f3)
            F3_B, F3_BU: nbytes = 1;
            F3_H, F3_HU: nbytes = 2;
            F3_W:        nbytes = 4;
            default:     nbytes = 0;
        endcase
        // Other opcodes, unknown widths and unsigned store codes
        bad = (!is_ld && !is_st) || (nbytes == 0) || (is_st && f3[2]);
        // Natural alignment only
        if (nbytes == 2 && addr[0]) begin
            bad = 1'b1;
        end
        if (nbytes == 4 && addr[1:0] != 2'b00) begin
            bad = 1'b1;
        end
        res.rob_idx = r.rob_idx;
        res.is_load = is_ld;
        res.fault   = bad;
        res.value   = '0;
        if (!bad && is_st) begin
            for (int k = 0; k < nbytes; k++) begin
                pos = addr[ADDR_LEN+1:0] + k[ADDR_LEN+1:0];
                shadow[pos] = r.rs2_value[8*k +: 8];
            end
        end else if (!bad && is_ld) begin
            data = '0;
            for (int k = 0; k < nbytes; k++) begin
                pos = addr[ADDR_LEN+1:0] + k[ADDR_LEN+1:0];
                data[8*k +: 8] = shadow[pos];
            end
            // funct3 bit 2 clear means sign extension
            if (!f3[2]) begin
                case (nbytes)
                    1:       data = {{24{data[7]}}, data[7:0]};
                    2:       data = {{16{data[15]}}, data[15:0]};
                    default: data = data;
                endcase
            end
            res.value = data;
        end
        return res;
    endfunction

    // Field by field check of one writeback record
    task automatic compare_wb(input lsu_wb_t got, input lsu_wb_t exp);
        if (got.rob_idx !== exp.rob_idx) begin
            $display("Fail at %0t ns: wb_o.rob_idx got %0d expected %0d",
                     $time, got.rob_idx, exp.rob_idx);
            value_errors++;
        end
        if (got.is_load !== exp.is_load) begin
            $display("Fail at %0t ns: wb_o.is_load got %b expected %b",
                     $time, got.is_load, exp.is_load);
            value_errors++;
        end
        if (got.fault !== exp.fault) begin
            $display("Fail at %0t ns: wb_o.fault got %b expected %b",
                     $time, got.fault, exp.fault);
            value_errors++;
        end
        if (got.value !== exp.value) begin
            $display("Fail at %0t ns: wb_o.value got %h expected %h",
                     $time, got.value, exp.value);
            value_errors++;
        end
    endtask

    // Compare process, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (wb_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t ns: writeback with rob_idx %0d but no request outstanding",
                         $time, wb.rob_idx);
                protocol_errors++;
            end else begin
                compare_wb(wb, exp_q.pop_front());
                checked++;
            end
        end
    end

    // One request in the next cycle, model updated at issue
    task automatic send(input logic [31:0] inst, input logic [31:0] rs1, input logic [31:0] rs2);
        lsu_req_t r;
        r.inst      = inst;
        r.rs1_value = rs1;
        r.rs2_value = rs2;
        r.rob_idx   = rob_cnt;
        @(negedge clk);
        req_valid = 1'b1;
        req       = r;
        exp_q.push_back(model_access(r));
        rob_cnt = rob_cnt + 5'd1;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    // Waits for all outstanding records, bounded
    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout at %0t ns: %0d expected writeback records never arrived",
                     $time, exp_q.size());
            protocol_errors++;
            exp_q.delete();
        end
    endtask

    // Word stores over the whole memory, then word loads back
    task automatic fill_and_readback();
        logic [31:0] data;
        for (int w = 0; w < MEM_WORDS; w++) begin
            data = next_random();
            // Negative immediate against a raised base
            send(store_inst(F3_W, 12'hfe0), w * 4 + 32, data);
        end
        for (int w = 0; w < MEM_WORDS; w++) begin
            send(load_inst(F3_W, 12'h010), w * 4 - 16, 32'h0);
        end
        drain();
    endtask

    // Byte and half stores at every legal offset, each followed by a word load
    task automatic store_subwords();
        logic [31:0] data;
        for (int w = 0; w < 12; w++) begin
            data = next_random();
            case (w % 6)
                4:       send(store_inst(F3_H, 12'h000), w * 4, data);
                5:       send(store_inst(F3_H, 12'h002), w * 4, data);
                default: send(store_inst(F3_B, 12'(w % 6)), w * 4, data);
            endcase
            send(load_inst(F3_W, 12'h000), w * 4, 32'h0);
        end
        drain();
    endtask

    // Every load width and signedness at every legal offset
    task automatic load_subwords();
        // Top bits set in several lanes
        send(store_inst(F3_W, 12'h000), 32'h30, 32'h80ff_7f01);
        send(store_inst(F3_W, 12'h000), 32'h34, 32'hfe81_8000);
        for (int w = 10; w < 14; w++) begin
            for (int off = 0; off < 4; off++) begin
                send(load_inst(F3_B, 12'(off)), w * 4, 32'h0);
                send(load_inst(F3_BU, 12'(off)), w * 4, 32'h0);
            end
            for (int off = 0; off < 4; off += 2) begin
                send(load_inst(F3_H, 12'(off)), w * 4, 32'h0);
                send(load_inst(F3_HU, 12'(off)), w * 4, 32'h0);
            end
            send(load_inst(F3_W, 12'h000), w * 4, 32'h0);
        end
        drain();
    endtask

    // Misaligned, illegal funct3 and non-memory opcodes
    task automatic issue_faults();
        send(load_inst(F3_H, 12'h001), 32'h40, 32'h0);
        send(load_inst(F3_HU, 12'h003), 32'h40, 32'h0);
        send(load_inst(F3_W, 12'h002), 32'h40, 32'h0);
        send(load_inst(F3_W, 12'h003), 32'h40, 32'h0);
        send(store_inst(F3_H, 12'h003), 32'h44, 32'hdead_beef);
        send(store_inst(F3_W, 12'h001), 32'h44, 32'hdead_beef);
        send(store_inst(F3_W, 12'h006), 32'h44, 32'hdead_beef);
        send(load_inst(3'b011, 12'h000), 32'h48, 32'h0);
        send(load_inst(3'b110, 12'h000), 32'h48, 32'h0);
        send(load_inst(3'b111, 12'h000), 32'h48, 32'h0);
        send(store_inst(F3_BU, 12'h000), 32'h48, 32'hdead_beef);
        send(store_inst(3'b011, 12'h000), 32'h48, 32'hdead_beef);
        // add x3, x1, x2 and addi x0, x0, 0
        send(32'h0020_81b3, 32'h48, 32'hdead_beef);
        send(32'h0000_0013, 32'h48, 32'hdead_beef);
        // Untouched words read back
        send(load_inst(F3_W, 12'h000), 32'h40, 32'h0);
        send(load_inst(F3_W, 12'h000), 32'h44, 32'h0);
        send(load_inst(F3_W, 12'h000), 32'h48, 32'h0);
        drain();
    endtask

    // Mixed requests every cycle, full 32-bit bases wrap around the memory
    task automatic random_traffic(input int count);
        logic [31:0] rnd;
        logic [31:0] base;
        logic [31:0] tmp;
        logic [31:0] data;
        logic [2:0]  f3;
        logic [1:0]  off;
        logic        skew;
        for (int n = 0; n < count; n++) begin
            rnd  = next_random();
            base = next_random() & 32'hffff_fffc;
            tmp  = next_random();
            data = next_random();
            off  = rnd[12:11];
            // Rare misaligned half or word
            skew = (rnd[15:13] == 3'b000);
            if (rnd[7:5] < 3'd3) begin
                case (rnd[10:8])
                    3'd0:    f3 = F3_B;
                    3'd1:    f3 = F3_BU;
                    3'd2:    f3 = F3_H;
                    3'd3:    f3 = F3_HU;
                    3'd7:    f3 = 3'b011;
                    default: f3 = F3_W;
                endcase
            end else begin
                case (rnd[9:8])
                    2'd0:    f3 = F3_B;
                    2'd1:    f3 = F3_H;
                    default: f3 = F3_W;
                endcase
            end
            if (!skew && f3[1:0] == SZ_HALF) begin
                off[0] = 1'b0;
            end
            if (!skew && f3[1:0] == SZ_WORD) begin
                off = 2'b00;
            end
            case (rnd[7:5])
                3'd0, 3'd1, 3'd2: send(load_inst(f3, {tmp[11:2], off}), base, data);
                3'd3, 3'd4, 3'd5: send(store_inst(f3, {tmp[11:2], off}), base, data);
                3'd6: begin
                    // Store then a word load of the same word in the next cycle
                    send(store_inst(f3, {tmp[11:2], off}), base, data);
                    send(load_inst(F3_W, {tmp[11:2], 2'b00}), base, 32'h0);
                end
                default: send(tmp, base, data);
            endcase
        end
        drain();
    endtask

    // Reset with requests in flight, their records are lost
    task automatic reset_during_traffic();
        random_traffic_no_drain(12);
        @(negedge clk);
        req_valid = 1'b0;
        rst       = 1'b1;
        // Records still in flight at the first reset edge must never show up
        @(posedge clk);
        exp_q.delete();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        // Any writeback here is reported by the compare process
        idle(8);
        // Memory survives reset
        for (int w = 0; w < 4; w++) begin
            send(load_inst(F3_W, 12'h000), w * 4, 32'h0);
        end
        drain();
    endtask

    // Short random burst left in flight
    task automatic random_traffic_no_drain(input int count);
        logic [31:0] base;
        logic [31:0] data;
        for (int n = 0; n < count; n++) begin
            base = next_random() & 32'hffff_fffc;
            data = next_random();
            if (data[0]) begin
                send(store_inst(F3_W, 12'h000), base, data);
            end else begin
                send(load_inst(F3_W, 12'h000), base, 32'h0);
            end
        end
    endtask

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        req_valid       = 1'b0;
        req             = '0;
        lcg_state       = 32'h91ed_e2a2;
        rob_cnt         = '0;
        value_errors    = 0;
        protocol_errors = 0;
        checked         = 0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        fill_and_readback();
        store_subwords();
        load_subwords();
        issue_faults();
        random_traffic(400);
        reset_during_traffic();
        $display("Result: %0d records checked, %0d value errors, %0d protocol errors",
                 checked, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: testbench/lsu_chk.sv
// Bound assertions on the load-store unit's request to writeback timing and fault records
module lsu_chk (
    input logic              clk_i,
    input logic              rst_i,
    input logic              req_valid_i,
    input logic              wb_valid_i,
    input lsu_pkg::lsu_wb_t  wb_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Fixed two cycle latency, every request gets its record
    req_gives_wb: assert property (
        @(posedge clk_i) disable iff (rst_i)
        $past(req_valid_i, 2) |-> wb_valid_i
    ) else $error("request without writeback two cycles later");

    // No record without a request two cycles earlier
    wb_needs_req: assert property (
        @(posedge clk_i) disable iff (rst_i)
        wb_valid_i |-> $past(req_valid_i, 2)
    ) else $error("writeback without a request two cycles earlier");

    // Faulted records carry zero
    fault_value_zero: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (wb_valid_i && wb_i.fault) |-> (wb_i.value == 32'h0)
    ) else $error("faulted writeback with nonzero value");

endmodule

bind lsu_top lsu_chk u_chk (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .wb_valid_i  (wb_valid_o),
    .wb_i        (wb_o)
);

// File: source/lsu_top.sv
// Load-store unit top level: address generator, data memory, tracker and writeback
module lsu_top #(
    parameter int unsigned DMEM_ADDR_LEN = 8
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                req_valid_i,
    input  lsu_pkg::lsu_req_t   req_i,
    output logic                wb_valid_o,
    output lsu_pkg::lsu_wb_t    wb_o
);
    import lsu_pkg::*;

    // Cycle N, from address generation
    mem_op_t      mem_op;
    access_info_t agen_info;

    // Cycle N+1, from memory and tracker
    logic [31:0]  rdata;
    logic         trk_valid;
    access_info_t trk_info;

    // Combinational decode and address
    lsu_agen u_agen (
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .mem_op_o    (mem_op),
        .info_o      (agen_info)
    );

    // Memory access, one cycle
    lsu_dmem #(
        .DMEM_ADDR_LEN (DMEM_ADDR_LEN)
    ) u_dmem (
        .clk_i    (clk_i),
        .mem_op_i (mem_op),
        .rdata_o  (rdata)
    );

    // Descriptor side by side with the memory
    lsu_track u_track (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (req_valid_i),
        .info_i  (agen_info),
        .valid_o (trk_valid),
        .info_o  (trk_info)
    );

    // Extraction and record register
    lsu_writeback u_writeback (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .valid_i    (trk_valid),
        .info_i     (trk_info),
        .rdata_i    (rdata),
        .wb_valid_o (wb_valid_o),
        .wb_o       (wb_o)
    );

endmodule

// File: source/lsu_writeback.sv
// Writeback stage: load lane extraction and extension, registered writeback record
module lsu_writeback (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    valid_i,
    input  lsu_pkg::access_info_t   info_i,
    input  logic [31:0]             rdata_i,
    output logic                    wb_valid_o,
    output lsu_pkg::lsu_wb_t        wb_o
);
    import lsu_pkg::*;

    logic [31:0] lane;
    logic [31:0] load_value;
    logic [31:0] value;

    // Addressed byte or half moved down to bit 0
    assign lane = rdata_i >> {info_i.byte_off, 3'b000};

    // Extension by size and signedness
    always_comb begin
        case (info_i.size)
            SZ_BYTE: begin
                load_value = {{24{info_i.is_signed & lane[7]}}, lane[7:0]};
            end
            SZ_HALF: begin
                load_value = {{16{info_i.is_signed & lane[15]}}, lane[15:0]};
            end
            // Word passes through unchanged
            default: begin
                load_value = rdata_i;
            end
        endcase
    end

    // Stores and faults report zero
    assign value = (info_i.is_load && !info_i.fault) ? load_value : 32'h0;

    // Record valid one cycle after the tracker
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= valid_i;
        end
    end

    // Record payload, held while idle
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            wb_o.rob_idx <= info_i.rob_idx;
            wb_o.is_load <= info_i.is_load;
            wb_o.fault   <= info_i.fault;
            wb_o.value   <= value;
        end
    end

endmodule

// File: source/lsu_track.sv
// Access tracker: one-cycle register of the in-flight request's tag and load descriptor
module lsu_track (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    valid_i,
    input  lsu_pkg::access_info_t   info_i,
    output logic                    valid_o,
    output lsu_pkg::access_info_t   info_o
);

    // Valid bit runs beside the memory read
    // so the read word and its descriptor meet in the same cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Descriptor loads only with a request
    // Faulting requests are tracked too, they still need a record
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            info_o <= info_i;
        end
    end

endmodule

// File: source/lsu_dmem.sv
// Word-wide data memory with byte-masked write and registered read
module lsu_dmem #(
    parameter int unsigned DMEM_ADDR_LEN = 8
) (
    input  logic               clk_i,
    input  lsu_pkg::mem_op_t   mem_op_i,
    output logic [31:0]        rdata_o
);

    localparam int unsigned DEPTH = 2 ** DMEM_ADDR_LEN;

    // Word storage, contents survive reset
    logic [31:0] mem [DEPTH];

    logic [DMEM_ADDR_LEN-1:0] word_addr;

    // Drop byte offset, upper bits above the memory size wrap
    assign word_addr = mem_op_i.byte_addr[DMEM_ADDR_LEN+1:2];

    // Masked write, one lane per byte
    always_ff @(posedge clk_i) begin
        if (mem_op_i.wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (mem_op_i.wmask[i]) begin
                    mem[word_addr][8*i +: 8] <= mem_op_i.wdata[8*i +: 8];
                end
            end
        end
    end

    // Registered read
    // Output holds the last read word while idle
    always_ff @(posedge clk_i) begin
        if (mem_op_i.rd_en) begin
            rdata_o <= mem[word_addr];
        end
    end

endmodule

// File: source/lsu_agen.sv
// Address generator: decode, effective address, legality and alignment, store lane placement
module lsu_agen (
    input  logic                    req_valid_i,
    input  lsu_pkg::lsu_req_t       req_i,
    output lsu_pkg::mem_op_t        mem_op_o,
    output lsu_pkg::access_info_t   info_o
);
    import lsu_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] addr;
    logic [1:0]  size;
    logic [1:0]  off;
    logic        is_load;
    logic        is_store;
    logic        f3_legal;
    logic        misaligned;
    logic        fault;
    logic [3:0]  lane_mask;
    logic [31:0] data_lane;

    // Instruction fields
    assign opcode = req_i.inst[6:0];
    assign funct3 = req_i.inst[14:12];

    // I immediate for loads, S immediate for stores, both sign extended
    assign imm_i = {{20{req_i.inst[31]}}, req_i.inst[31:20]};
    assign imm_s = {{20{req_i.inst[31]}}, req_i.inst[31:25], req_i.inst[11:7]};

    assign is_load  = (opcode == OP_LOAD);
    assign is_store = (opcode == OP_STORE);

    // Effective byte address
    assign addr = req_i.rs1_value + (is_store ? imm_s : imm_i);
    assign off  = addr[1:0];
    assign size = funct3[1:0];

    // Legal funct3 per class
    always_comb begin
        f3_legal = 1'b0;
        if (is_load) begin
            f3_legal = (funct3 == F3_B)  || (funct3 == F3_H)  || (funct3 == F3_W) ||
                       (funct3 == F3_BU) || (funct3 == F3_HU);
        end else if (is_store) begin
            f3_legal = (funct3 == F3_B) || (funct3 == F3_H) || (funct3 == F3_W);
        end
    end

    // Halfwords need an even address, words a multiple of four
    always_comb begin
        case (size)
            SZ_HALF: misaligned = off[0];
            SZ_WORD: misaligned = (off != 2'b00);
            default: misaligned = 1'b0;
        endcase
    end

    // Non-memory opcodes fault as well, since f3_legal stays low
    assign fault = !f3_legal || misaligned;

    // Store lanes and data before shifting to the byte offset
    always_comb begin
        case (size)
            SZ_BYTE: begin
                lane_mask = 4'b0001;
                data_lane = {24'h0, req_i.rs2_value[7:0]};
            end
            SZ_HALF: begin
                lane_mask = 4'b0011;
                data_lane = {16'h0, req_i.rs2_value[15:0]};
            end
            default: begin
                lane_mask = 4'b1111;
                data_lane = req_i.rs2_value;
            end
        endcase
    end

    // Memory strobes, both low on a fault or without a request
    assign mem_op_o.rd_en     = req_valid_i && is_load && !fault;
    assign mem_op_o.wr_en     = req_valid_i && is_store && !fault;
    assign mem_op_o.byte_addr = addr;
    // Mask only on an actual write
    assign mem_op_o.wmask     = mem_op_o.wr_en ? (lane_mask << off) : 4'b0000;
    assign mem_op_o.wdata     = data_lane << {off, 3'b000};

    // Descriptor for writeback
    assign info_o.rob_idx   = req_i.rob_idx;
    assign info_o.is_load   = is_load;
    // funct3 bit 2 marks the unsigned loads
    assign info_o.is_signed = is_load && !funct3[2];
    assign info_o.size      = size;
    assign info_o.byte_off  = off;
    assign info_o.fault     = fault;

endmodule

// File: source/lsu_pkg.sv
// Load-store unit package: opcodes, funct3 codes, access sizes and shared packed structs
package lsu_pkg;

    // RISC-V major opcodes handled by the unit
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    // Funct3 codes for width and signedness
    // Stores use only the B, H and W codes
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    // Access size, same as the low two bits of funct3
    localparam logic [1:0] SZ_BYTE = 2'b00;
    localparam logic [1:0] SZ_HALF = 2'b01;
    localparam logic [1:0] SZ_WORD = 2'b10;

    // One dispatched request from issue
    typedef struct packed {
        // Raw instruction word
        logic [31:0] inst;
        // Base register value
        logic [31:0] rs1_value;
        // Store data register value
        logic [31:0] rs2_value;
        // Reorder buffer tag
        logic [4:0]  rob_idx;
    } lsu_req_t;

    // One memory access from address generation
    typedef struct packed {
        // Read strobe, load only
        logic        rd_en;
        // Write strobe, store only
        logic        wr_en;
        // Full byte address, memory keeps only the bits it needs
        logic [31:0] byte_addr;
        // Byte lanes written by a store
        logic [3:0]  wmask;
        // Store data, already placed in its lanes
        logic [31:0] wdata;
    } mem_op_t;

    // Request descriptor carried alongside the memory access
    typedef struct packed {
        // Reorder buffer tag
        logic [4:0] rob_idx;
        // Set for loads, clear for stores and non-memory opcodes
        logic       is_load;
        // Load extends with the sign bit
        logic       is_signed;
        // Byte, half or word
        logic [1:0] size;
        // Low address bits, select the lane at writeback
        logic [1:0] byte_off;
        // Illegal or misaligned access
        logic       fault;
    } access_info_t;

    // Writeback record returned to the core
    typedef struct packed {
        // Reorder buffer tag
        logic [4:0]  rob_idx;
        // Record belongs to a load
        logic        is_load;
        // Access faulted, value is zero
        logic        fault;
        // Load result, zero for stores and faults
        logic [31:0] value;
    } lsu_wb_t;

endpackage
